//--- common/rs_pkg.sv
package rs_pkg;

    // station geometry
    localparam int rs_size = 8;
    localparam int rs_cnt_width = $clog2(rs_size + 1);

    // tag 0 means no tag and is never broadcast
    localparam int tag_width = 6;
    localparam int data_width = 32;

    // dispatch opcode is {class, op}
    localparam int op_width = 2;
    localparam int code_width = op_width + 1;

    localparam logic fu_alu_code = 1'b0;
    localparam logic fu_mult_code = 1'b1;

    localparam logic [op_width-1:0] op_add = 2'd0;
    localparam logic [op_width-1:0] op_sub = 2'd1;
    localparam logic [op_width-1:0] op_and = 2'd2;
    localparam logic [op_width-1:0] op_xor = 2'd3;

    localparam logic [code_width-1:0] op_mul = {fu_mult_code, {op_width{1'b0}}};

    // multiplier timing
    localparam int mult_latency = 3;
    localparam int mult_cnt_width = $clog2(mult_latency);

    // operand slot holds the value once ready or the producer tag while waiting
    typedef union packed {
        logic [data_width-1:0] value;
        struct packed {
            logic [data_width-tag_width-1:0] unused;
            logic [tag_width-1:0] tag;
        } pending;
    } operand_word;

endpackage

//--- common/cdb_if.sv
`timescale 1ns/1ps

interface cdb_if;

    logic valid;
    logic [rs_pkg::tag_width-1:0] tag;
    logic [rs_pkg::data_width-1:0] value;
    logic ready;

    modport source (
        output valid, tag, value,
        input  ready
    );

    modport sink (
        input  valid, tag, value,
        output ready
    );

endinterface

//--- rs/psel_gen.sv
`timescale 1ns/1ps

module psel_gen #(
    parameter int width = 8
) (
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt,
    output logic             empty
);

    // scan from the top so the lowest request wins
    always_comb begin
        gnt = '0;
        for (int i = width - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt = '0;
                gnt[i] = 1'b1;
            end
        end
    end

    assign empty = ~|req; // nothing to grant

endmodule

//--- rs/rs.sv
`timescale 1ns/1ps

module rs (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                disp_valid,
    input  logic [rs_pkg::code_width-1:0]       disp_op,
    input  logic [rs_pkg::tag_width-1:0]        disp_dest,
    input  logic                                disp_a_ready,
    input  rs_pkg::operand_word                 disp_a,
    input  logic                                disp_b_ready,
    input  rs_pkg::operand_word                 disp_b,
    output logic                                disp_ready,
    cdb_if.sink                                 cdb,
    output logic                                alu_valid,
    input  logic                                alu_ready,
    output logic [rs_pkg::op_width-1:0]         alu_op,
    output logic [rs_pkg::data_width-1:0]       alu_a,
    output logic [rs_pkg::data_width-1:0]       alu_b,
    output logic [rs_pkg::tag_width-1:0]        alu_dest,
    output logic                                mult_valid,
    input  logic                                mult_ready,
    output logic [rs_pkg::data_width-1:0]       mult_a,
    output logic [rs_pkg::data_width-1:0]       mult_b,
    output logic [rs_pkg::tag_width-1:0]        mult_dest
);

    // entry state
    logic [rs_pkg::rs_size-1:0]      valid_q;
    logic [rs_pkg::code_width-1:0]   op_q [rs_pkg::rs_size];
    logic [rs_pkg::tag_width-1:0]    dest_q [rs_pkg::rs_size];
    logic [rs_pkg::rs_size-1:0]      a_rdy_q;
    logic [rs_pkg::rs_size-1:0]      b_rdy_q;
    rs_pkg::operand_word             a_q [rs_pkg::rs_size];
    rs_pkg::operand_word             b_q [rs_pkg::rs_size];
    logic [rs_pkg::rs_cnt_width-1:0] count_q;

    logic [rs_pkg::rs_size-1:0] free_sel;
    logic [rs_pkg::rs_size-1:0] a_hit;
    logic [rs_pkg::rs_size-1:0] b_hit;
    logic [rs_pkg::rs_size-1:0] alu_req;
    logic [rs_pkg::rs_size-1:0] mult_req;
    logic [rs_pkg::rs_size-1:0] alu_gnt;
    logic [rs_pkg::rs_size-1:0] mult_gnt;
    logic disp_fire, disp_a_hit, disp_b_hit;
    logic alu_fire, mult_fire, alu_empty, mult_empty;

    assign cdb.ready = 1'b1; // station always listens
    assign disp_ready = count_q < rs_pkg::rs_cnt_width'(rs_pkg::rs_size);
    assign disp_fire = disp_valid && disp_ready;

    // lowest free slot
    always_comb begin
        free_sel = '0;
        for (int i = rs_pkg::rs_size - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_sel = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            a_hit[i] = cdb.valid && !a_rdy_q[i] && (a_q[i].pending.tag == cdb.tag);
            b_hit[i] = cdb.valid && !b_rdy_q[i] && (b_q[i].pending.tag == cdb.tag);
            alu_req[i] = valid_q[i] && a_rdy_q[i] && b_rdy_q[i]
                         && (op_q[i][rs_pkg::op_width] == rs_pkg::fu_alu_code);
            mult_req[i] = valid_q[i] && a_rdy_q[i] && b_rdy_q[i]
                          && (op_q[i][rs_pkg::op_width] == rs_pkg::fu_mult_code);
        end
    end

    // wakeup of an operation arriving this cycle
    assign disp_a_hit = cdb.valid && !disp_a_ready && (disp_a.pending.tag == cdb.tag);
    assign disp_b_hit = cdb.valid && !disp_b_ready && (disp_b.pending.tag == cdb.tag);

    psel_gen #(.width(rs_pkg::rs_size)) alu_sel (
        .req   (alu_req),
        .gnt   (alu_gnt),
        .empty (alu_empty)
    );

    psel_gen #(.width(rs_pkg::rs_size)) mult_sel (
        .req   (mult_req),
        .gnt   (mult_gnt),
        .empty (mult_empty)
    );

    assign alu_valid = !alu_empty;
    assign mult_valid = !mult_empty;
    assign alu_fire = alu_valid && alu_ready;
    assign mult_fire = mult_valid && mult_ready;

    // one-hot grant mux
    always_comb begin
        alu_op = '0;
        alu_a = '0;
        alu_b = '0;
        alu_dest = '0;
        mult_a = '0;
        mult_b = '0;
        mult_dest = '0;
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            if (alu_gnt[i]) begin
                alu_op = op_q[i][rs_pkg::op_width-1:0];
                alu_a = a_q[i].value;
                alu_b = b_q[i].value;
                alu_dest = dest_q[i];
            end
            if (mult_gnt[i]) begin
                mult_a = a_q[i].value;
                mult_b = b_q[i].value;
                mult_dest = dest_q[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            valid_q <= (valid_q | ({rs_pkg::rs_size{disp_fire}} & free_sel))
                       & ~({rs_pkg::rs_size{alu_fire}} & alu_gnt)
                       & ~({rs_pkg::rs_size{mult_fire}} & mult_gnt);
            count_q <= count_q + rs_pkg::rs_cnt_width'(disp_fire)
                       - rs_pkg::rs_cnt_width'(alu_fire)
                       - rs_pkg::rs_cnt_width'(mult_fire);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_pkg::rs_size; i++) begin
            if (disp_fire && free_sel[i]) begin
                op_q[i] <= disp_op;
                dest_q[i] <= disp_dest;
                a_rdy_q[i] <= disp_a_ready || disp_a_hit;
                b_rdy_q[i] <= disp_b_ready || disp_b_hit;
                a_q[i] <= disp_a;
                b_q[i] <= disp_b;
                if (disp_a_hit) a_q[i].value <= cdb.value;
                if (disp_b_hit) b_q[i].value <= cdb.value;
            end else begin
                if (a_hit[i]) begin
                    a_rdy_q[i] <= 1'b1;
                    a_q[i].value <= cdb.value;
                end
                if (b_hit[i]) begin
                    b_rdy_q[i] <= 1'b1;
                    b_q[i].value <= cdb.value;
                end
            end
        end
    end

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    output logic                          issue_ready,
    input  logic [rs_pkg::op_width-1:0]   op,
    input  logic [rs_pkg::data_width-1:0] a,
    input  logic [rs_pkg::data_width-1:0] b,
    input  logic [rs_pkg::tag_width-1:0]  dest,
    cdb_if.source                         result
);

    logic                          full_q;
    logic [rs_pkg::tag_width-1:0]  tag_q;
    logic [rs_pkg::data_width-1:0] value_q;
    logic [rs_pkg::data_width-1:0] res;
    logic                          issue_fire;

    always_comb begin
        res = '0;
        case (op)
            rs_pkg::op_add: res = a + b;
            rs_pkg::op_sub: res = a - b;
            rs_pkg::op_and: res = a & b;
            rs_pkg::op_xor: res = a ^ b;
        endcase
    end

    assign issue_ready = !full_q || result.ready; // empty or draining
    assign issue_fire = issue_valid && issue_ready;

    assign result.valid = full_q;
    assign result.tag = tag_q;
    assign result.value = value_q;

    always_ff @(posedge clock) begin
        if (reset) full_q <= 1'b0;
        else if (issue_fire) full_q <= 1'b1;
        else if (result.ready) full_q <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            value_q <= res;
            tag_q <= dest;
        end
    end

endmodule

//--- hdl/mult_unit.sv
`timescale 1ns/1ps

module mult_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          issue_valid,
    output logic                          issue_ready,
    input  logic [rs_pkg::data_width-1:0] a,
    input  logic [rs_pkg::data_width-1:0] b,
    input  logic [rs_pkg::tag_width-1:0]  dest,
    cdb_if.source                         result
);

    logic                              busy_q;
    logic [rs_pkg::mult_cnt_width-1:0] cnt_q;
    logic [rs_pkg::data_width-1:0]     a_q;
    logic [rs_pkg::data_width-1:0]     b_q;
    logic [rs_pkg::data_width-1:0]     prod_q;
    logic [rs_pkg::tag_width-1:0]      tag_q;
    logic                              issue_fire;

    assign issue_ready = !busy_q; // one operation at a time
    assign issue_fire = issue_valid && !busy_q;

    assign result.valid = busy_q && (cnt_q == '0);
    assign result.tag = tag_q;
    assign result.value = prod_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q <= '0;
        end else if (issue_fire) begin
            busy_q <= 1'b1;
            cnt_q <= rs_pkg::mult_cnt_width'(rs_pkg::mult_latency - 1);
        end else if (busy_q && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (result.valid && result.ready) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            a_q <= a;
            b_q <= b;
            tag_q <= dest;
        end
        if (busy_q && cnt_q != '0) prod_q <= a_q * b_q; // low word only
    end

endmodule

//--- hdl/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic  clock,
    input  logic  reset,
    cdb_if.sink   mult_in,
    cdb_if.sink   alu_in,
    cdb_if.source bus
);

    logic                          valid_q;
    logic [rs_pkg::tag_width-1:0]  tag_q;
    logic [rs_pkg::data_width-1:0] value_q;
    logic                          take_mult;
    logic                          take_alu;

    // multiplier has priority over the alu
    assign mult_in.ready = bus.ready;
    assign alu_in.ready = bus.ready && !mult_in.valid;

    assign take_mult = mult_in.valid && mult_in.ready;
    assign take_alu = alu_in.valid && alu_in.ready;

    assign bus.valid = valid_q;
    assign bus.tag = tag_q;
    assign bus.value = value_q;

    always_ff @(posedge clock) begin
        if (reset) valid_q <= 1'b0;
        else valid_q <= take_mult || take_alu; // one-cycle pulse per result
    end

    always_ff @(posedge clock) begin
        if (take_mult) begin
            tag_q <= mult_in.tag;
            value_q <= mult_in.value;
        end else if (take_alu) begin
            tag_q <= alu_in.tag;
            value_q <= alu_in.value;
        end
    end

endmodule

//--- hdl/rs_top.sv
`timescale 1ns/1ps

module rs_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          disp_valid,
    input  logic [rs_pkg::code_width-1:0] disp_op,
    input  logic [rs_pkg::tag_width-1:0]  disp_dest,
    input  logic                          disp_a_ready,
    input  rs_pkg::operand_word           disp_a,
    input  logic                          disp_b_ready,
    input  rs_pkg::operand_word           disp_b,
    output logic                          disp_ready,
    output logic                          cdb_valid,
    output logic [rs_pkg::tag_width-1:0]  cdb_tag,
    output logic [rs_pkg::data_width-1:0] cdb_value
);

    logic                          alu_valid, alu_ready, mult_valid, mult_ready;
    logic [rs_pkg::op_width-1:0]   alu_op;
    logic [rs_pkg::data_width-1:0] alu_a, alu_b, mult_a, mult_b;
    logic [rs_pkg::tag_width-1:0]  alu_dest, mult_dest;

    cdb_if alu_res ();
    cdb_if mult_res ();
    cdb_if bcast ();

    rs u_rs (
        .clock, .reset, .disp_valid, .disp_op, .disp_dest,
        .disp_a_ready, .disp_a, .disp_b_ready, .disp_b, .disp_ready,
        .cdb (bcast.sink),
        .alu_valid, .alu_ready, .alu_op, .alu_a, .alu_b, .alu_dest,
        .mult_valid, .mult_ready, .mult_a, .mult_b, .mult_dest
    );

    alu_unit u_alu (
        .clock, .reset, .issue_valid (alu_valid), .issue_ready (alu_ready),
        .op (alu_op), .a (alu_a), .b (alu_b), .dest (alu_dest), .result (alu_res.source)
    );

    mult_unit u_mult (
        .clock, .reset, .issue_valid (mult_valid), .issue_ready (mult_ready),
        .a (mult_a), .b (mult_b), .dest (mult_dest), .result (mult_res.source)
    );

    cdb_arbiter u_arb (
        .clock, .reset, .mult_in (mult_res.sink), .alu_in (alu_res.sink), .bus (bcast.source)
    );

    assign cdb_valid = bcast.valid;
    assign cdb_tag = bcast.tag;
    assign cdb_value = bcast.value;

endmodule

//--- sim/rs_chk.sv
`timescale 1ns/1ps

module rs_chk (
    input logic                            clock,
    input logic                            reset,
    input logic                            cdb_valid,
    input logic [rs_pkg::tag_width-1:0]    cdb_tag,
    input logic [rs_pkg::rs_size-1:0]      entry_valid,
    input logic [rs_pkg::rs_cnt_width-1:0] entry_count,
    input logic                            alu_valid,
    input logic                            mult_valid,
    input logic                            disp_ready
);

    no_tag_zero: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_tag != '0)
        else $error("broadcast carried tag 0");

    // issue needs an occupied entry
    issue_from_entry: assert property (@(posedge clock) disable iff (reset)
        (alu_valid || mult_valid) |-> entry_count != '0)
        else $error("issue requested from an empty station");

    full_blocks_dispatch: assert property (@(posedge clock) disable iff (reset)
        &entry_valid |-> !disp_ready)
        else $error("dispatch open while every entry is valid");

endmodule

bind rs rs_chk u_chk (
    .clock       (clock),
    .reset       (reset),
    .cdb_valid   (cdb.valid),
    .cdb_tag     (cdb.tag),
    .entry_valid (valid_q),
    .entry_count (count_q),
    .alu_valid   (alu_valid),
    .mult_valid  (mult_valid),
    .disp_ready  (disp_ready)
);

//--- sim/rs_tb.sv
`timescale 1ns/1ps

module rs_tb;

    localparam int total_ops = 6 + 8 + 6 + 14 + 40;
    localparam int timeout_limit = total_ops * 20 + 200;
    localparam int tag_count = 2 ** rs_pkg::tag_width;

    logic clock, reset, disp_valid, disp_a_ready, disp_b_ready, disp_ready, cdb_valid;
    logic [rs_pkg::code_width-1:0] disp_op;
    logic [rs_pkg::tag_width-1:0]  disp_dest, cdb_tag;
    rs_pkg::operand_word           disp_a, disp_b;
    logic [rs_pkg::data_width-1:0] cdb_value;

    logic [rs_pkg::data_width-1:0] exp_value [tag_count]; // reference model
    bit     expected [tag_count];
    bit     seen [tag_count];
    int     errors, bcast_count, cycle_count;
    bit     full_seen;
    integer seed;

    rs_top uut (
        .clock, .reset, .disp_valid, .disp_op, .disp_dest, .disp_a_ready, .disp_a,
        .disp_b_ready, .disp_b, .disp_ready, .cdb_valid, .cdb_tag, .cdb_value
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [rs_pkg::code_width-1:0] alu_code(input logic [1:0] op);
        return {rs_pkg::fu_alu_code, op};
    endfunction

    function automatic logic [31:0] ref_result(input logic [2:0] code,
                                               input logic [31:0] a, input logic [31:0] b);
        if (code[rs_pkg::op_width] == rs_pkg::fu_mult_code) return a * b; // low word
        case (code[rs_pkg::op_width-1:0])
            rs_pkg::op_add: return a + b;
            rs_pkg::op_sub: return a - b;
            rs_pkg::op_and: return a & b;
            default:        return a ^ b;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // broadcasts sampled mid-cycle
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            bcast_count++;
            if (!expected[cdb_tag])
                report_failure($sformatf("unexpected tag %0d on the CDB", cdb_tag));
            else if (seen[cdb_tag])
                report_failure($sformatf("tag %0d broadcast a second time", cdb_tag));
            else
                check_equal($sformatf("cdb_value tag %0d", cdb_tag), cdb_value,
                            exp_value[cdb_tag]);
            seen[cdb_tag] = 1'b1;
        end
    end

    task automatic clear_model();
        for (int t = 0; t < tag_count; t++) begin
            expected[t] = 1'b0;
            seen[t] = 1'b0;
        end
        full_seen = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    // a tag of 0 means the immediate is used
    task automatic send_op(input logic [2:0] code, input logic [5:0] dest,
                           input logic [5:0] a_tag, input logic [31:0] a_imm,
                           input logic [5:0] b_tag, input logic [31:0] b_imm);
        logic [31:0] a_val;
        logic [31:0] b_val;
        logic        accepted;
        a_val = (a_tag == 0) ? a_imm : exp_value[a_tag];
        b_val = (b_tag == 0) ? b_imm : exp_value[b_tag];
        exp_value[dest] = ref_result(code, a_val, b_val);
        expected[dest] = 1'b1;
        seen[dest] = 1'b0;
        accepted = 1'b0;
        while (!accepted) begin
            disp_valid = 1'b1;
            disp_op = code;
            disp_dest = dest;
            disp_a_ready = (a_tag == 0) || seen[a_tag]; // producer already broadcast
            disp_a = a_val;
            if (!disp_a_ready) begin
                disp_a = '0;
                disp_a.pending.tag = a_tag;
            end
            disp_b_ready = (b_tag == 0) || seen[b_tag];
            disp_b = b_val;
            if (!disp_b_ready) begin
                disp_b = '0;
                disp_b.pending.tag = b_tag;
            end
            accepted = disp_ready;
            if (!disp_ready) full_seen = 1'b1;
            idle(1);
        end
        disp_valid = 1'b0;
    endtask

    function automatic bit all_arrived();
        for (int t = 0; t < tag_count; t++)
            if (expected[t] && !seen[t]) return 1'b0;
        return 1'b1;
    endfunction

    task automatic drain_and_confirm(input int n_ops, input string test_name);
        int waited;
        waited = 0;
        while (!all_arrived() && waited < n_ops * 20 + 50) begin
            idle(1);
            waited++;
        end
        idle(4); // catch late strays
        for (int t = 0; t < tag_count; t++)
            if (expected[t] && !seen[t])
                report_failure($sformatf("%s: tag %0d never arrived", test_name, t));
    endtask

    task automatic wait_for_tag(input logic [5:0] tag);
        int waited;
        waited = 0;
        while (!(cdb_valid && cdb_tag == tag) && waited < 50) begin
            idle(1);
            waited++;
        end
        if (waited >= 50) report_failure($sformatf("tag %0d never showed on the CDB", tag));
    endtask

    task automatic after_reset_state();
        check_equal("cdb_valid", 32'(cdb_valid), 32'd0);
        check_equal("disp_ready", 32'(disp_ready), 32'd1);
    endtask

    task automatic independent_alu_ops();
        clear_model();
        send_op(alu_code(rs_pkg::op_add), 6'd1, 0, 32'd100, 0, 32'd23);
        send_op(alu_code(rs_pkg::op_sub), 6'd2, 0, 32'd5, 0, 32'd9);
        send_op(alu_code(rs_pkg::op_and), 6'd3, 0, 32'hf0f0_ff00, 0, 32'h3c3c_0ff0);
        send_op(alu_code(rs_pkg::op_xor), 6'd4, 0, 32'hdead_beef, 0, 32'h1234_5678);
        send_op(alu_code(rs_pkg::op_add), 6'd5, 0, 32'hffff_ffff, 0, 32'd2);
        send_op(alu_code(rs_pkg::op_sub), 6'd6, 0, 32'd0, 0, 32'd1);
        drain_and_confirm(6, "alu ops");
    endtask

    // the xor result lands in the same cycle as the first product
    task automatic mult_with_alu_mix();
        clear_model();
        send_op(rs_pkg::op_mul, 6'd1, 0, 32'h1234_5678, 0, 32'h9abc_def1);
        send_op(alu_code(rs_pkg::op_add), 6'd2, 0, 32'd7, 0, 32'd8);
        send_op(alu_code(rs_pkg::op_xor), 6'd4, 0, 32'h5555_aaaa, 0, 32'h0f0f_0f0f);
        send_op(alu_code(rs_pkg::op_sub), 6'd6, 0, 32'd1000, 0, 32'd1);
        send_op(rs_pkg::op_mul, 6'd3, 0, 32'hffff_ffff, 0, 32'hffff_fffe);
        send_op(rs_pkg::op_mul, 6'd5, 0, 32'd40000, 0, 32'd70000);
        send_op(rs_pkg::op_mul, 6'd7, 0, 32'h8000_0001, 0, 32'd3);
        send_op(alu_code(rs_pkg::op_and), 6'd8, 0, 32'hffff_0000, 0, 32'h00ff_ff00);
        drain_and_confirm(8, "mult ops");
    endtask

    task automatic dependent_chain();
        clear_model();
        send_op(rs_pkg::op_mul, 6'd1, 0, 32'd3, 0, 32'd5);
        wait_for_tag(6'd1); // consumer meets its producer's broadcast
        send_op(alu_code(rs_pkg::op_add), 6'd2, 6'd1, 0, 0, 32'd7);
        send_op(rs_pkg::op_mul, 6'd3, 6'd2, 0, 6'd2, 0);
        send_op(alu_code(rs_pkg::op_xor), 6'd4, 6'd3, 0, 6'd1, 0);
        send_op(alu_code(rs_pkg::op_sub), 6'd5, 6'd4, 0, 6'd2, 0);
        send_op(rs_pkg::op_mul, 6'd6, 6'd5, 0, 6'd3, 0);
        drain_and_confirm(6, "dependent chain");
    endtask

    task automatic station_fill();
        clear_model();
        send_op(rs_pkg::op_mul, 6'd1, 0, 32'd5, 0, 32'h0001_0003);
        for (int k = 2; k <= 8; k++)
            send_op(rs_pkg::op_mul, 6'(k), 6'(k - 1), 0, 0, 32'h0001_0003);
        for (int k = 9; k <= 14; k++)
            send_op(alu_code(2'(k)), 6'(k), 6'd8, 0, 0, 32'(k * 1111));
        if (!full_seen) report_failure("disp_ready never dropped with the station full");
        drain_and_confirm(14, "station fill");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [2:0]  code;
        logic [5:0]  a_tag, b_tag;
        logic [31:0] a_imm, b_imm;
        clear_model();
        for (int i = 1; i <= 40; i++) begin
            r = $random(seed);
            code = (r[1:0] == 2'd0) ? rs_pkg::op_mul : alu_code(r[3:2]);
            a_tag = '0;
            b_tag = '0;
            if (i > 1 && r[4]) a_tag = 6'(1 + ($unsigned($random(seed)) % (i - 1)));
            if (i > 1 && r[5]) b_tag = 6'(1 + ($unsigned($random(seed)) % (i - 1)));
            a_imm = $random(seed);
            b_imm = $random(seed);
            send_op(code, 6'(i), a_tag, a_imm, b_tag, b_imm);
            if (r[6]) idle(int'(r[8:7]) + 1); // gap in disp_valid
        end
        drain_and_confirm(40, "random mix");
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        $display("error count %0d, broadcasts %0d", errors, bcast_count);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed = 32'h2173_200c;
        errors = 0;
        bcast_count = 0;
        reset = 1'b1;
        disp_valid = 1'b0;
        disp_op = '0;
        disp_dest = '0;
        disp_a_ready = 1'b0;
        disp_a = '0;
        disp_b_ready = 1'b0;
        disp_b = '0;
        clear_model();
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        after_reset_state();
        independent_alu_ops();
        mult_with_alu_mix();
        dependent_chain();
        station_fill();
        random_mix();
        $display("error count %0d, broadcasts %0d", errors, bcast_count);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- src.f
common/rs_pkg.sv
common/cdb_if.sv
rs/psel_gen.sv
rs/rs.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/cdb_arbiter.sv
hdl/rs_top.sv
sim/rs_chk.sv
sim/rs_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rs_tb -f src.f -o rs_sim

./obj_dir/rs_sim > sim.log 2>&1 || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
